//--- common/long_pkg.sv
/*
  shared types and sizes for the long-latency execution back end
  compile first, every module refers to it by scoped names
*/
`default_nettype none

package long_pkg;

    localparam int REG_ADDR_WIDTH  = 5;   // register number
    localparam int SB_DEPTH        = 8;   // scoreboard entries
    localparam int COMMIT_ID_WIDTH = 3;   // log2 of SB_DEPTH
    localparam int XLEN            = 32;  // operand width
    localparam int MUL_STAGES      = 3;   // multiplier latency
    localparam int DIV_CNT_WIDTH   = 5;   // counts 32 divider steps

    // long opcodes
    typedef enum logic [2:0] {
        OP_MUL   = 3'd0,  // low half of product
        OP_MULHU = 3'd1,  // high half of product
        OP_DIVU  = 3'd2,  // quotient, x/0 = all ones
        OP_REMU  = 3'd3,  // remainder, x/0 = x
        OP_FENCE = 3'd4   // drain, no writeback
    } long_op_e;

    typedef enum logic {
        CTRL_RUN   = 1'b0,
        CTRL_DRAIN = 1'b1  // fence seen, waiting for empty scoreboard
    } ctrl_state_e;

    // instruction as offered on the issue port
    typedef struct packed {
        long_op_e                  op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic                      rd_we;
        logic                      rs1_re;
        logic                      rs2_re;
        logic [XLEN-1:0]           a;   // rs1 value
        logic [XLEN-1:0]           b;   // rs2 value
    } long_instr_t;

    // request into a unit, rd rides along for the completion
    typedef struct packed {
        long_op_e                   op;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [XLEN-1:0]            a;
        logic [XLEN-1:0]            b;
        logic [COMMIT_ID_WIDTH-1:0] id;
    } exec_req_t;

    typedef struct packed {
        logic [COMMIT_ID_WIDTH-1:0] id;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [XLEN-1:0]            result;
    } exec_cpl_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [XLEN-1:0]            result;
        logic [COMMIT_ID_WIDTH-1:0] id;
    } wb_t;

endpackage

`default_nettype wire

//--- hdu/hdu.sv
/*
  scoreboard hazard unit for long instructions
  one entry per in-flight destination, indexed by commit id
  stall is combinational, entries update on the clock edge
*/
`default_nettype none

module hdu (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 alloc_i,    // candidate issued
    input  wire logic [long_pkg::REG_ADDR_WIDTH-1:0]  rd_i,
    input  wire logic [long_pkg::REG_ADDR_WIDTH-1:0]  rs1_i,
    input  wire logic [long_pkg::REG_ADDR_WIDTH-1:0]  rs2_i,
    input  wire logic                                 rd_we_i,
    input  wire logic                                 rs1_re_i,
    input  wire logic                                 rs2_re_i,
    input  wire logic                                 release_valid_i,  // writeback handshake
    input  wire logic [long_pkg::COMMIT_ID_WIDTH-1:0] release_id_i,
    output logic                                      stall_o,
    output logic      [long_pkg::COMMIT_ID_WIDTH-1:0] alloc_id_o,  // lowest free entry
    output logic                                      lock_o       // anything outstanding
);

    logic [long_pkg::SB_DEPTH-1:0]       sb_valid;
    logic [long_pkg::SB_DEPTH-1:0]       sb_we;   // entry writes a register
    logic [long_pkg::REG_ADDR_WIDTH-1:0] sb_rd [long_pkg::SB_DEPTH];

    logic [long_pkg::SB_DEPTH-1:0] live;     // valid and not leaving this cycle
    logic [long_pkg::SB_DEPTH-1:0] raw_vec;
    logic [long_pkg::SB_DEPTH-1:0] waw_vec;

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < long_pkg::SB_DEPTH; i++) begin
            live[i] = sb_valid[i] &&
                      !(release_valid_i && release_id_i == long_pkg::COMMIT_ID_WIDTH'(i));
            raw_vec[i] = live[i] && sb_we[i] &&
                         ((rs1_re_i && rs1_i == sb_rd[i]) ||
                          (rs2_re_i && rs2_i == sb_rd[i]));
            waw_vec[i] = live[i] && sb_we[i] && rd_we_i && rd_i == sb_rd[i];
        end
    end

    // full test looks at the registered bits, release counts next cycle
    assign stall_o = (|raw_vec) || (|waw_vec) || (&sb_valid);
    assign lock_o  = |sb_valid;

    // priority pick, walk down so index 0 wins
    always_comb begin
        alloc_id_o = '0;
        for (int i = long_pkg::SB_DEPTH - 1; i >= 0; i--) begin
            if (!sb_valid[i]) begin
                alloc_id_o = long_pkg::COMMIT_ID_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_valid <= '0;
        end else begin
            if (release_valid_i) begin
                sb_valid[release_id_i] <= 1'b0;
            end
            if (alloc_i) begin
                sb_valid[alloc_id_o] <= 1'b1;  // never the released id, that one is busy
            end
        end
    end

    // tag storage, only meaningful under sb_valid
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            sb_rd[alloc_id_o] <= rd_i;
            sb_we[alloc_id_o] <= rd_we_i;
        end
    end

endmodule

`default_nettype wire

//--- design/div_unit.sv
/*
  iterative unsigned divider, restoring shift-subtract
  one op at a time, result 34 cycles after acceptance and held until taken
*/
`default_nettype none

module div_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req_valid_i,
    input  wire long_pkg::exec_req_t req_i,
    input  wire logic                cpl_ready_i,
    output logic                     req_ready_o,
    output logic                     cpl_valid_o,
    output long_pkg::exec_cpl_t      cpl_o
);

    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_LOAD,   // seed remainder and quotient
        DIV_ITER,   // 32 steps
        DIV_RES,    // pick quotient or remainder
        DIV_DONE    // wait for the arbiter
    } div_state_e;

    div_state_e                       state_q;
    logic [long_pkg::DIV_CNT_WIDTH-1:0] cnt_q;
    long_pkg::exec_req_t              req_q;
    logic [long_pkg::XLEN-1:0]        rem_q;
    logic [long_pkg::XLEN-1:0]        quo_q;   // dividend shifts out, quotient shifts in
    logic [long_pkg::XLEN:0]          trial;

    assign trial       = {rem_q, quo_q[long_pkg::XLEN-1]} - {1'b0, req_q.b};
    assign req_ready_o = state_q == DIV_IDLE;
    assign cpl_valid_o = state_q == DIV_DONE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                DIV_IDLE: if (req_valid_i) state_q <= DIV_LOAD;
                DIV_LOAD: begin
                    state_q <= DIV_ITER;
                    cnt_q   <= '0;
                end
                DIV_ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (&cnt_q) state_q <= DIV_RES;  // last of 32
                end
                DIV_RES:  state_q <= DIV_DONE;
                DIV_DONE: if (cpl_ready_i) state_q <= DIV_IDLE;
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == DIV_LOAD) begin
            rem_q <= '0;
            quo_q <= req_q.a;
        end
        if (state_q == DIV_ITER) begin
            if (!trial[long_pkg::XLEN]) begin              // no borrow, keep difference
                rem_q <= trial[long_pkg::XLEN-1:0];
                quo_q <= {quo_q[long_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[long_pkg::XLEN-2:0], quo_q[long_pkg::XLEN-1]};
                quo_q <= {quo_q[long_pkg::XLEN-2:0], 1'b0};
            end
        end
        if (state_q == DIV_RES) begin
            cpl_o.id <= req_q.id;
            cpl_o.rd <= req_q.rd;
            if (req_q.b == '0) begin
                cpl_o.result <= (req_q.op == long_pkg::OP_DIVU) ? '1 : req_q.a;
            end else begin
                cpl_o.result <= (req_q.op == long_pkg::OP_DIVU) ? quo_q : rem_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mul_unit.sv
/*
  three-stage unsigned multiplier, up to three ops in flight
  partial products, sum, then low or high half select
  the whole pipe freezes while its output waits
*/
`default_nettype none

module mul_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req_valid_i,
    input  wire long_pkg::exec_req_t req_i,
    input  wire logic                cpl_ready_i,
    output logic                     req_ready_o,
    output logic                     cpl_valid_o,
    output long_pkg::exec_cpl_t      cpl_o
);

    localparam int HALF = long_pkg::XLEN / 2;

    logic [long_pkg::MUL_STAGES-1:0] vld_q;   // one bit per stage
    logic                            adv;
    long_pkg::exec_req_t             s1_q, s2_q;
    logic [long_pkg::XLEN+HALF-1:0]  pp_lo_q;  // a low half times b
    logic [long_pkg::XLEN+HALF-1:0]  pp_hi_q;  // a high half times b
    logic [2*long_pkg::XLEN-1:0]     prod_q;

    assign cpl_valid_o = vld_q[long_pkg::MUL_STAGES-1];
    assign adv         = !(cpl_valid_o && !cpl_ready_i);
    assign req_ready_o = adv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (adv) begin
            vld_q <= {vld_q[long_pkg::MUL_STAGES-2:0], req_valid_i};
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            s1_q    <= req_i;
            pp_lo_q <= req_i.a[HALF-1:0] * req_i.b;
            pp_hi_q <= req_i.a[long_pkg::XLEN-1:HALF] * req_i.b;
            s2_q    <= s1_q;
            prod_q  <= {{HALF{1'b0}}, pp_lo_q} + {pp_hi_q, {HALF{1'b0}}};
            cpl_o.id     <= s2_q.id;
            cpl_o.rd     <= s2_q.rd;
            cpl_o.result <= (s2_q.op == long_pkg::OP_MULHU) ?
                            prod_q[2*long_pkg::XLEN-1:long_pkg::XLEN] :
                            prod_q[long_pkg::XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
/*
  merges divider and multiplier completions onto the writeback port
  divider first, a waiting multiplier result stays granted until taken
*/
`default_nettype none

module wb_arbiter (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 div_valid_i,
    input  wire long_pkg::exec_cpl_t                  div_cpl_i,
    input  wire logic                                 mul_valid_i,
    input  wire long_pkg::exec_cpl_t                  mul_cpl_i,
    input  wire logic                                 wb_ready_i,
    output logic                                      div_ready_o,
    output logic                                      mul_ready_o,
    output logic                                      wb_valid_o,
    output long_pkg::wb_t                             wb_o,
    output logic                                      release_valid_o,
    output logic      [long_pkg::COMMIT_ID_WIDTH-1:0] release_id_o
);

    logic                mul_hold_q;   // mul offered last cycle and not taken
    logic                sel_div;
    long_pkg::exec_cpl_t cpl;

    assign sel_div     = div_valid_i && !mul_hold_q;
    assign cpl         = sel_div ? div_cpl_i : mul_cpl_i;
    assign wb_valid_o  = div_valid_i || mul_valid_i;
    assign div_ready_o = wb_ready_i && sel_div;
    assign mul_ready_o = wb_ready_i && !sel_div;

    always_comb begin
        wb_o.rd     = cpl.rd;
        wb_o.result = cpl.result;
        wb_o.id     = cpl.id;
    end

    // frees the scoreboard entry on the handshake
    assign release_valid_o = wb_valid_o && wb_ready_i;
    assign release_id_o    = cpl.id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_hold_q <= 1'b0;
        end else begin
            mul_hold_q <= mul_valid_i && !sel_div && !wb_ready_i;
        end
    end

endmodule

`default_nettype wire

//--- design/issue_ctrl.sv
/*
  issue controller, accepts one instruction per cycle
  steers multiply and divide ops to their unit and runs the fence drain
*/
`default_nettype none

module issue_ctrl (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 instr_valid_i,
    input  wire long_pkg::long_instr_t                instr_i,
    input  wire logic                                 stall_i,     // hazard or full
    input  wire logic [long_pkg::COMMIT_ID_WIDTH-1:0] alloc_id_i,
    input  wire logic                                 lock_i,      // scoreboard not empty
    input  wire logic                                 div_ready_i,
    input  wire logic                                 mul_ready_i,
    output logic                                      instr_ready_o,
    output logic                                      alloc_o,
    output logic                                      div_req_valid_o,
    output logic                                      mul_req_valid_o,
    output long_pkg::exec_req_t                       req_o
);

    long_pkg::ctrl_state_e state_q;
    logic                  live_q;   // low until the first edge after reset
    logic                  is_div;
    logic                  is_mul;
    logic                  is_fence;
    logic                  fire;

    assign is_div   = instr_i.op == long_pkg::OP_DIVU || instr_i.op == long_pkg::OP_REMU;
    assign is_mul   = instr_i.op == long_pkg::OP_MUL || instr_i.op == long_pkg::OP_MULHU;
    assign is_fence = instr_i.op == long_pkg::OP_FENCE;

    // ready from current state only, valid not looked at
    always_comb begin
        if (is_div) begin
            instr_ready_o = live_q && div_ready_i && !stall_i;
        end else if (is_mul) begin
            instr_ready_o = live_q && mul_ready_i && !stall_i;
        end else if (is_fence) begin
            instr_ready_o = live_q && state_q == long_pkg::CTRL_DRAIN && !lock_i;
        end else begin
            instr_ready_o = 1'b0;  // unknown op never issues
        end
    end

    assign fire            = instr_valid_i && instr_ready_o;
    assign alloc_o         = fire && !is_fence;  // fence takes no entry
    assign div_req_valid_o = fire && is_div;
    assign mul_req_valid_o = fire && is_mul;

    always_comb begin
        req_o.op = instr_i.op;
        req_o.rd = instr_i.rd;
        req_o.a  = instr_i.a;
        req_o.b  = instr_i.b;
        req_o.id = alloc_id_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= long_pkg::CTRL_RUN;
            live_q  <= 1'b0;
        end else begin
            live_q <= 1'b1;
            unique case (state_q)
                long_pkg::CTRL_RUN: begin
                    if (instr_valid_i && is_fence) begin
                        state_q <= long_pkg::CTRL_DRAIN;  // stop issue, wait for empty
                    end
                end
                long_pkg::CTRL_DRAIN: begin
                    if (fire) begin
                        state_q <= long_pkg::CTRL_RUN;   // fence retired
                    end
                end
                default: state_q <= long_pkg::CTRL_RUN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/long_exec_top.sv
/*
  long-latency execution back end
  valid/ready issue in, valid/ready writeback out, busy while work is in flight
*/
`default_nettype none

module long_exec_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  instr_valid_i,
    input  wire long_pkg::long_instr_t instr_i,
    input  wire logic                  wb_ready_i,
    output logic                       instr_ready_o,
    output logic                       wb_valid_o,
    output long_pkg::wb_t              wb_o,
    output logic                       busy_o
);

    logic                                 stall;
    logic                                 alloc;
    logic [long_pkg::COMMIT_ID_WIDTH-1:0] alloc_id;
    logic                                 rel_valid;
    logic [long_pkg::COMMIT_ID_WIDTH-1:0] rel_id;
    long_pkg::exec_req_t                  req;
    logic                                 div_req_valid, div_req_ready;
    logic                                 mul_req_valid, mul_ready;
    logic                                 div_cpl_valid, div_cpl_ready;
    logic                                 mul_cpl_valid, mul_cpl_ready;
    long_pkg::exec_cpl_t                  div_cpl, mul_cpl;

    hdu u_hdu (
        .clk, .rst_n,
        .alloc_i(alloc), .rd_i(instr_i.rd), .rs1_i(instr_i.rs1), .rs2_i(instr_i.rs2),
        .rd_we_i(instr_i.rd_we), .rs1_re_i(instr_i.rs1_re), .rs2_re_i(instr_i.rs2_re),
        .release_valid_i(rel_valid), .release_id_i(rel_id),
        .stall_o(stall), .alloc_id_o(alloc_id), .lock_o(busy_o)   // busy is the lock flag
    );

    issue_ctrl u_ctrl (
        .clk, .rst_n, .instr_valid_i, .instr_i,
        .stall_i(stall), .alloc_id_i(alloc_id), .lock_i(busy_o),
        .div_ready_i(div_req_ready), .mul_ready_i(mul_ready),
        .instr_ready_o, .alloc_o(alloc),
        .div_req_valid_o(div_req_valid), .mul_req_valid_o(mul_req_valid), .req_o(req)
    );

    div_unit u_div (
        .clk, .rst_n, .req_valid_i(div_req_valid), .req_i(req), .cpl_ready_i(div_cpl_ready),
        .req_ready_o(div_req_ready), .cpl_valid_o(div_cpl_valid), .cpl_o(div_cpl)
    );

    mul_unit u_mul (
        .clk, .rst_n, .req_valid_i(mul_req_valid), .req_i(req), .cpl_ready_i(mul_cpl_ready),
        .req_ready_o(mul_ready), .cpl_valid_o(mul_cpl_valid), .cpl_o(mul_cpl)
    );

    wb_arbiter u_arb (
        .clk, .rst_n,
        .div_valid_i(div_cpl_valid), .div_cpl_i(div_cpl),
        .mul_valid_i(mul_cpl_valid), .mul_cpl_i(mul_cpl), .wb_ready_i,
        .div_ready_o(div_cpl_ready), .mul_ready_o(mul_cpl_ready),
        .wb_valid_o, .wb_o, .release_valid_o(rel_valid), .release_id_o(rel_id)
    );

endmodule

`default_nettype wire

//--- bench/long_exec_sva.sv
/*
  handshake and scoreboard assertions, bound into the top level
  scoreboard valid bits are taken from the hazard unit inside it
*/
`default_nettype none

module long_exec_sva (
    input wire logic                                 clk,
    input wire logic                                 rst_n,
    input wire logic                                 alloc,
    input wire logic                                 stall,
    input wire logic                                 rel_valid,
    input wire logic [long_pkg::COMMIT_ID_WIDTH-1:0] rel_id,
    input wire logic [long_pkg::SB_DEPTH-1:0]        sb_valid,
    input wire logic                                 wb_valid,
    input wire logic                                 wb_ready,
    input wire long_pkg::wb_t                        wb
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // never take an entry past a hazard or a full scoreboard
    alloc_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !stall) else begin
        fail_count++;
        $error("alloc while stall is high");
    end

    release_valid_entry: assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid |-> sb_valid[rel_id]) else begin
        fail_count++;
        $error("release of an invalid entry");
    end

    // payload held until taken
    wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb)) else begin
        fail_count++;
        $error("wb payload changed");
    end

endmodule

bind long_exec_top long_exec_sva sva0 (
    .clk, .rst_n, .alloc(alloc), .stall(stall), .rel_valid(rel_valid), .rel_id(rel_id),
    .sb_valid(u_hdu.sb_valid), .wb_valid(wb_valid_o), .wb_ready(wb_ready_i), .wb(wb_o)
);

`default_nettype wire

//--- bench/tb_long_exec.sv
/*
  directed testbench for the long-latency execution back end
  a reference queue predicts each writeback and the monitor matches it by rd
  tests run in order from one initial block, a cycle watchdog bounds the run
*/
`default_nettype none

module tb_long_exec;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 20000;  // 5 tests x 40 instrs x 35 cycles, ~3x margin

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid_i;
    long_pkg::long_instr_t instr_i;
    logic                  wb_ready_i;
    logic                  instr_ready_o;
    logic                  wb_valid_o;
    long_pkg::wb_t         wb_o;
    logic                  busy_o;

    long_pkg::wb_t exp_q[$];    // predicted writebacks, oldest first
    int            wb_log[$];   // rd of every writeback in order
    string         test_name = "none";
    integer        seed = 32'h4808;
    logic [31:0]   rnd;
    int            wb_mode = 1; // 0 low, 1 high, 2 random
    int            errors = 0;
    int            checks = 0;
    int            issued = 0;
    int            wb_count = 0;
    int            cycles = 0;
    int            mon_hit;

    logic [long_pkg::SB_DEPTH-1:0]        id_busy = '0;  // commit ids held in the model
    logic [long_pkg::COMMIT_ID_WIDTH-1:0] next_id = '0;  // id the next accept gets

    long_exec_top dut0 (
        .clk, .rst_n, .instr_valid_i, .instr_i, .wb_ready_i,
        .instr_ready_o, .wb_valid_o, .wb_o, .busy_o
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // writeback back-pressure, changes only on the falling edge
    always @(negedge clk) begin
        if (wb_mode == 2) begin
            rnd = $random(seed);
            wb_ready_i = rnd[0];
        end else begin
            wb_ready_i = (wb_mode == 1);
        end
    end

    // commit ids are handed out lowest first
    function automatic logic [long_pkg::COMMIT_ID_WIDTH-1:0] lowest_free(
            input logic [long_pkg::SB_DEPTH-1:0] used);
        for (int i = 0; i < long_pkg::SB_DEPTH; i++) begin
            if (!used[i]) return long_pkg::COMMIT_ID_WIDTH'(i);
        end
        return '0;
    endfunction

    // model settles between edges
    always @(negedge clk) begin
        next_id = lowest_free(id_busy);
    end

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // pre-edge values at the rising edge, match by rd, oldest entry first
    always @(posedge clk) begin
        if (rst_n && wb_valid_o && wb_ready_i) begin
            mon_hit = -1;
            for (int i = 0; i < exp_q.size(); i++) begin
                if (mon_hit < 0 && exp_q[i].rd == wb_o.rd) mon_hit = i;
            end
            if (mon_hit < 0) begin
                errors++;
                $display("%s: writeback to x%0d with nothing outstanding for it",
                         test_name, wb_o.rd);
            end else begin
                check_eq("result", exp_q[mon_hit].result, wb_o.result);
                check_eq("commit id", exp_q[mon_hit].id, wb_o.id);
                id_busy[exp_q[mon_hit].id] = 1'b0;  // entry freed on the handshake
                exp_q.delete(mon_hit);
            end
            wb_count++;
            wb_log.push_back(int'(wb_o.rd));
        end
    end

    // opcode rules, unsigned only
    function automatic logic [31:0] expect_result(input long_pkg::long_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            long_pkg::OP_MUL:   return prod[31:0];
            long_pkg::OP_MULHU: return prod[63:32];
            long_pkg::OP_DIVU:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
            long_pkg::OP_REMU:  return (b == 32'd0) ? a : a % b;
            default:            return 32'd0;
        endcase
    endfunction

    // offer on the falling edge, return at the accepting rising edge, valid left high
    task automatic issue(input long_pkg::long_op_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [31:0] a, input logic [31:0] b, output int waited);
        long_pkg::long_instr_t ins;
        long_pkg::wb_t         e;
        ins.op     = op;
        ins.rd     = rd;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.rd_we  = (op != long_pkg::OP_FENCE);
        ins.rs1_re = (op != long_pkg::OP_FENCE);
        ins.rs2_re = (op != long_pkg::OP_FENCE);
        ins.a      = a;
        ins.b      = b;
        waited     = 0;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        @(posedge clk);
        while (!instr_ready_o) begin
            waited++;
            @(posedge clk);
        end
        issued++;
        if (op != long_pkg::OP_FENCE) begin
            e.rd     = rd;
            e.result = expect_result(op, a, b);
            e.id     = next_id;
            id_busy[next_id] = 1'b1;
            exp_q.push_back(e);
        end
    endtask

    task automatic stop_issue();
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || busy_o) @(posedge clk);
    endtask

    task automatic set_wb_mode(input int m);
        @(posedge clk);
        wb_mode = m;
    endtask

    task automatic issue_random(input int count);
        logic [31:0]        r;
        logic [31:0]        a;
        logic [31:0]        b;
        long_pkg::long_op_e op;
        int                 w;
        for (int i = 0; i < count; i++) begin
            r  = $random(seed);
            a  = $random(seed);
            b  = $random(seed);
            b  = b >> r[6:2];                     // spread divisor sizes
            op = long_pkg::long_op_e'({1'b0, r[1:0]});
            if (i % 10 == 2) begin
                op = long_pkg::OP_DIVU;           // zero divisor cases
                b  = '0;
            end
            if (i % 10 == 3) begin
                op = long_pkg::OP_REMU;
                b  = '0;
            end
            issue(op, 5'(1 + i % 8), 5'(20 + i % 4), 5'(24 + i % 4), a, b, w);
        end
        stop_issue();
    endtask

    task automatic test_reset();
        test_name = "reset";
        repeat (16) @(posedge clk);
        check_eq("ready in reset", 0, instr_ready_o);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("busy", 0, busy_o);
        check_eq("wb_valid", 0, wb_valid_o);
    endtask

    task automatic test_arith();
        int base;
        test_name = "arith";
        base = wb_count;
        issue_random(40);
        drain();
        check_eq("writebacks", 40, wb_count - base);
    endtask

    task automatic test_raw();
        int w;
        test_name = "raw";
        wb_log.delete();
        issue(long_pkg::OP_DIVU, 5, 20, 21, 32'd1000, 32'd7, w);
        issue(long_pkg::OP_MUL, 6, 5, 22, 32'd142, 32'd3, w);  // reads x5
        stop_issue();
        drain();
        check_eq("mul held back", 1, w >= 33);
        check_eq("writebacks", 2, wb_log.size());
        check_eq("first rd", 5, wb_log[0]);
        check_eq("second rd", 6, wb_log[1]);
    endtask

    task automatic test_full();
        int base;
        int base_is;
        int w;
        test_name = "full";
        base    = wb_count;
        base_is = issued;
        set_wb_mode(0);
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    issue(long_pkg::OP_MUL, 5'(10 + i), 20, 21, 32'(i + 3), 32'h1234_5678, w);
                end
                issue(long_pkg::OP_MULHU, 10, 22, 23, 32'hdead_beef, 32'd77, w);  // WAW on x10
                stop_issue();
            end
            begin
                repeat (12) @(posedge clk);
                check_eq("ready dropped", 0, instr_ready_o);
                check_eq("accepted while blocked", long_pkg::MUL_STAGES, issued - base_is);
                check_eq("busy while blocked", 1, busy_o);
                wb_mode = 1;
            end
        join
        drain();
        // divider holds x9, multiplier is free, only WAW keeps the mul back
        issue(long_pkg::OP_DIVU, 9, 20, 21, 32'd5000, 32'd3, w);
        issue(long_pkg::OP_MUL, 9, 22, 23, 32'd11, 32'd13, w);
        stop_issue();
        check_eq("WAW held", 1, w >= 33);
        drain();
        check_eq("writebacks", 11, wb_count - base);
    endtask

    task automatic test_backpressure();
        int base_wb;
        int base_is;
        test_name = "backpressure";
        base_wb = wb_count;
        base_is = issued;
        set_wb_mode(2);
        issue_random(40);
        drain();
        set_wb_mode(1);
        check_eq("results vs issues", issued - base_is, wb_count - base_wb);
    endtask

    task automatic test_fence();
        int base;
        int w;
        test_name = "fence";
        base = wb_count;
        issue(long_pkg::OP_DIVU, 7, 20, 21, 32'd100, 32'd9, w);
        stop_issue();
        check_eq("busy behind divide", 1, busy_o);
        issue(long_pkg::OP_FENCE, 0, 0, 0, 32'd0, 32'd0, w);
        check_eq("busy at fence accept", 0, busy_o);
        stop_issue();
        check_eq("fence waited for drain", 1, w >= 30);
        repeat (10) @(posedge clk);
        check_eq("writebacks", 1, wb_count - base);  // divide only
    endtask

    initial begin
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        wb_ready_i    = 1'b0;
        test_reset();
        test_arith();
        test_raw();
        test_full();
        test_backpressure();
        test_fence();
        errors = errors + dut0.sva0.fail_count;  // assertion failures count too
        $display("checks %0d, errors %0d, issued %0d, written back %0d",
                 checks, errors, issued, wb_count);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/long_pkg.sv
hdu/hdu.sv
design/div_unit.sv
design/mul_unit.sv
design/wb_arbiter.sv
design/issue_ctrl.sv
design/long_exec_top.sv
bench/long_exec_sva.sv
bench/tb_long_exec.sv

//--- Bender.yml
package:
  name: long_exec

sources:
  - common/long_pkg.sv
  - hdu/hdu.sv
  - design/div_unit.sv
  - design/mul_unit.sv
  - design/wb_arbiter.sv
  - design/issue_ctrl.sv
  - design/long_exec_top.sv
  - target: simulation
    files:
      - bench/long_exec_sva.sv
      - bench/tb_long_exec.sv
